// File: eth_test_pkg.sv
/*
 * ethernet test harness types
 * stream beat, PHY port status and link decode constants
 */
package eth_test_pkg;

    // ------------------------------------------------------------------------
    // byte stream, one beat per clock, no back-pressure
    // ------------------------------------------------------------------------
    typedef struct packed {
        logic       valid;
        // first byte of a frame
        logic       sof;
        // last byte of a frame
        logic       eof;
        logic [7:0] data;
    } byte_stream_t;

    // ------------------------------------------------------------------------
    // PHY status word as reported by the MAC, 4 bits per port
    // ------------------------------------------------------------------------
    typedef struct packed {
        logic       duplex;
        logic [1:0] speed;
        logic       link;
    } port_status_t;

    // speed code for 1000BASE-T
    localparam logic [1:0] SPEED_1G = 2'd2;

    // wrapping event counters
    typedef logic [15:0] err_count_t;

endpackage

// File: regs_pkg.sv
/*
 * register map of the test harness
 * addresses, word type and control bit layout
 */
package regs_pkg;

    typedef logic [3:0]  reg_addr_t;
    typedef logic [31:0] reg_data_t;

    // control word, low three bits of ADDR_CTRL
    typedef struct packed {
        // write 1 to drop the latched test error, self clearing
        logic err_clear;
        // hides the error blink on the LED
        logic led_mask;
        // enables the frame generator
        logic run;
    } ctrl_reg_t;

    // ------------------------------------------------------------------------
    // address map
    // ------------------------------------------------------------------------
    localparam reg_addr_t ADDR_CTRL        = 4'd0;
    // bit 0 test error, bits 8 and up link state per port
    localparam reg_addr_t ADDR_STATUS      = 4'd1;
    localparam reg_addr_t ADDR_GOOD_FRAMES = 4'd2;
    // port n error counter sits at base + n
    localparam reg_addr_t ADDR_RX_ERR_BASE = 4'd4;

endpackage

// File: ctrl_regs.sv
`timescale 1ns/100ps
/*
 * control and status register block
 * strobe driven writes, registered read mux, error clear pulse
 */
module ctrl_regs
    import eth_test_pkg::*;
    import regs_pkg::*;
#(
    parameter int PORT_COUNT = 4
) (
    input  logic                             clk20_g,
    input  logic                             reset_i,
    // register bus
    input  logic                             wr_en_i,
    input  logic                             rd_en_i,
    input  reg_addr_t                        addr_i,
    input  reg_data_t                        wdata_i,
    output reg_data_t                        rdata_o,
    output logic                             rd_valid_o,
    // status from the test and monitor logic
    input  logic                             test_err_i,
    input  err_count_t                       good_frames_i,
    input  logic [PORT_COUNT-1:0]            link_up_i,
    input  err_count_t [PORT_COUNT-1:0]      rx_err_count_i,
    // control out
    output ctrl_reg_t                        ctrl_o,
    output logic                             err_clear_o
);

    logic      run_q;
    logic      led_mask_q;
    logic      err_clear_q;
    logic      ctrl_wr;
    reg_data_t rd_mux;

    assign ctrl_wr = wr_en_i && (addr_i == ADDR_CTRL);

    // ------------------------------------------------------------------------
    // control register
    // ------------------------------------------------------------------------
    always_ff @(posedge clk20_g) begin
        if (reset_i) begin
            run_q       <= 1'b0;
            led_mask_q  <= 1'b0;
            err_clear_q <= 1'b0;
        end else begin
            // clear pulse only lives for the cycle after the write
            err_clear_q <= ctrl_wr && wdata_i[2];
            if (ctrl_wr) begin
                run_q      <= wdata_i[0];
                led_mask_q <= wdata_i[1];
            end
        end
    end

    assign ctrl_o      = '{err_clear: err_clear_q, led_mask: led_mask_q, run: run_q};
    assign err_clear_o = err_clear_q;

    // ------------------------------------------------------------------------
    // read side
    // ------------------------------------------------------------------------
    always_comb begin
        rd_mux = '0;
        case (addr_i)
            ADDR_CTRL: begin
                // err_clear is a pulse, reads back as zero
                rd_mux[0] = run_q;
                rd_mux[1] = led_mask_q;
            end
            ADDR_STATUS: begin
                rd_mux[0]              = test_err_i;
                rd_mux[8 +: PORT_COUNT] = link_up_i;
            end
            ADDR_GOOD_FRAMES: begin
                rd_mux[15:0] = good_frames_i;
            end
            default: begin
                // per port error counters, anything else stays zero
                for (int p = 0; p < PORT_COUNT; p++) begin
                    if (addr_i == reg_addr_t'(ADDR_RX_ERR_BASE + p)) begin
                        rd_mux[15:0] = rx_err_count_i[p];
                    end
                end
            end
        endcase
    end

    always_ff @(posedge clk20_g) begin
        if (reset_i) begin
            rd_valid_o <= 1'b0;
        end else begin
            rd_valid_o <= rd_en_i;
        end
    end

    // data word, only sampled while rd_valid_o is high
    always_ff @(posedge clk20_g) begin
        if (rd_en_i) begin
            rdata_o <= rd_mux;
        end
    end

endmodule

// File: test_frame_gen.sv
`timescale 1ns/100ps
/*
 * test frame generator
 * counting byte frames with a fixed inter-frame gap while run is set
 */
module test_frame_gen
    import eth_test_pkg::*;
#(
    parameter int FRAME_LEN = 64
) (
    input  logic         clk20_g,
    input  logic         reset_i,
    input  logic         run_i,
    output byte_stream_t tx_stream_o
);

    localparam int               IDX_W    = $clog2(FRAME_LEN + 1);
    localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(FRAME_LEN - 1);
    // idle cycles between eof and the next sof
    localparam logic [3:0]       GAP_LAST = 4'd11;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SEND,
        ST_GAP
    } gen_state_e;

    gen_state_e       state_q;
    logic [IDX_W-1:0] idx_q;
    logic [7:0]       frame_q;
    logic [3:0]       gap_q;

    always_ff @(posedge clk20_g) begin
        if (reset_i) begin
            state_q <= ST_IDLE;
            idx_q   <= '0;
            frame_q <= '0;
            gap_q   <= '0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (run_i) begin
                        state_q <= ST_SEND;
                        idx_q   <= '0;
                    end
                end
                ST_SEND: begin
                    // a cleared run still lets the frame run out
                    if (idx_q == LAST_IDX) begin
                        state_q <= ST_GAP;
                        gap_q   <= '0;
                        frame_q <= frame_q + 8'd1;
                    end else begin
                        idx_q <= idx_q + 1'b1;
                    end
                end
                ST_GAP: begin
                    if (gap_q == GAP_LAST) begin
                        idx_q   <= '0;
                        // back to back frames skip idle to keep the gap at 12
                        state_q <= run_i ? ST_SEND : ST_IDLE;
                    end else begin
                        gap_q <= gap_q + 4'd1;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // beat decode, byte k of frame f is f + k
    always_comb begin
        tx_stream_o.valid = (state_q == ST_SEND);
        tx_stream_o.sof   = tx_stream_o.valid && (idx_q == '0);
        tx_stream_o.eof   = tx_stream_o.valid && (idx_q == LAST_IDX);
        tx_stream_o.data  = frame_q + 8'(idx_q);
    end

endmodule

// File: test_frame_chk.sv
`timescale 1ns/100ps
/*
 * test frame checker
 * compares received frames to the counting pattern, sticky error, good count
 */
module test_frame_chk
    import eth_test_pkg::*;
#(
    parameter int FRAME_LEN = 64
) (
    input  logic         clk20_g,
    input  logic         reset_i,
    input  byte_stream_t rx_stream_i,
    input  logic         err_clear_i,
    output logic         test_err_o,
    output err_count_t   good_frames_o
);

    localparam int               IDX_W    = $clog2(FRAME_LEN + 1);
    localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(FRAME_LEN - 1);

    logic             in_frame_q;
    logic             frame_bad_q;
    logic [IDX_W-1:0] idx_q;
    logic [7:0]       exp_frame_q;
    logic             test_err_q;
    err_count_t       good_cnt_q;

    logic [IDX_W-1:0] cur_idx;
    logic [7:0]       cur_frame;
    logic             cur_bad;
    logic             beat_err;
    logic             clean_eof;

    // ------------------------------------------------------------------------
    // per beat check
    // ------------------------------------------------------------------------
    always_comb begin
        cur_idx   = idx_q;
        cur_frame = exp_frame_q;
        cur_bad   = frame_bad_q;
        beat_err  = 1'b0;
        if (rx_stream_i.valid) begin
            if (rx_stream_i.sof) begin
                cur_idx = '0;
                cur_bad = 1'b0;
                // sof inside a frame, previous eof never came
                if (in_frame_q) begin
                    beat_err  = 1'b1;
                    cur_frame = exp_frame_q + 8'd1;
                end
            end else if (!in_frame_q) begin
                // stray beat between frames
                beat_err = 1'b1;
            end
            if (rx_stream_i.data != cur_frame + 8'(cur_idx)) begin
                beat_err = 1'b1;
            end
            // early eof, or last index without eof
            if (rx_stream_i.eof != (cur_idx == LAST_IDX)) begin
                beat_err = 1'b1;
            end
        end
    end

    assign clean_eof = rx_stream_i.valid && rx_stream_i.eof && !beat_err && !cur_bad;

    // ------------------------------------------------------------------------
    // frame tracking
    // ------------------------------------------------------------------------
    always_ff @(posedge clk20_g) begin
        if (reset_i) begin
            in_frame_q  <= 1'b0;
            frame_bad_q <= 1'b0;
            idx_q       <= '0;
            exp_frame_q <= '0;
        end else if (rx_stream_i.valid) begin
            if (rx_stream_i.eof) begin
                // every eof moves on, good or bad
                in_frame_q  <= 1'b0;
                frame_bad_q <= 1'b0;
                exp_frame_q <= cur_frame + 8'd1;
            end else begin
                in_frame_q  <= in_frame_q || rx_stream_i.sof;
                frame_bad_q <= cur_bad || beat_err;
                exp_frame_q <= cur_frame;
                idx_q       <= cur_idx + 1'b1;
            end
        end
    end

    // sticky error and good frame count
    always_ff @(posedge clk20_g) begin
        if (reset_i) begin
            test_err_q <= 1'b0;
            good_cnt_q <= '0;
        end else begin
            test_err_q <= (test_err_q && !err_clear_i) || beat_err;
            if (clean_eof) begin
                good_cnt_q <= good_cnt_q + 1'b1;
            end
        end
    end

    assign test_err_o    = test_err_q;
    assign good_frames_o = good_cnt_q;

endmodule

// File: link_monitor.sv
`timescale 1ns/100ps
/*
 * per port link monitor
 * gigabit link decode and bad frame counters
 */
module link_monitor
    import eth_test_pkg::*;
#(
    parameter int PORT_COUNT = 4
) (
    input  logic                          clk20_g,
    input  logic                          reset_i,
    input  port_status_t [PORT_COUNT-1:0] port_status_i,
    input  logic [PORT_COUNT-1:0]         rx_bad_i,
    input  logic [PORT_COUNT-1:0]         rx_err_i,
    output logic [PORT_COUNT-1:0]         link_up_o,
    output err_count_t [PORT_COUNT-1:0]   rx_err_count_o
);

    for (genvar p = 0; p < PORT_COUNT; p++) begin : g_port
        logic       link_up_q;
        err_count_t cnt_q;

        // counting only makes sense with the link up at 1G
        always_ff @(posedge clk20_g) begin
            if (reset_i) begin
                link_up_q <= 1'b0;
            end else begin
                link_up_q <= port_status_i[p].link &&
                             (port_status_i[p].speed == SPEED_1G);
            end
        end

        // held at zero while down, wraps at 16 bits
        always_ff @(posedge clk20_g) begin
            if (reset_i || !link_up_q) begin
                cnt_q <= '0;
            end else if (rx_bad_i[p] || rx_err_i[p]) begin
                cnt_q <= cnt_q + 1'b1;
            end
        end

        assign link_up_o[p]      = link_up_q;
        assign rx_err_count_o[p] = cnt_q;
    end

endmodule

// File: led_blinker.sv
`timescale 1ns/100ps
/*
 * status LED blinker
 * us and ms timebase, blinks while a test error is latched
 */
module led_blinker #(
    parameter int CLK_PER_US    = 20,
    parameter int BLINK_HALF_MS = 125
) (
    input  logic clk20_g,
    input  logic reset_i,
    input  logic test_err_i,
    input  logic led_mask_i,
    output logic led_o
);

    localparam int US_PER_MS = 1000;
    localparam int US_W      = $clog2(CLK_PER_US + 1);
    localparam int MS_W      = $clog2(US_PER_MS + 1);
    localparam int HALF_W    = $clog2(BLINK_HALF_MS + 1);

    logic [US_W-1:0]   us_cnt_q;
    logic [MS_W-1:0]   ms_cnt_q;
    logic [HALF_W-1:0] half_cnt_q;
    logic              blink_q;

    logic              us_tick;
    logic              ms_tick;
    logic              half_tick;

    // tick chain, each stage only moves on the tick below it
    assign us_tick   = (us_cnt_q == US_W'(CLK_PER_US - 1));
    assign ms_tick   = us_tick && (ms_cnt_q == MS_W'(US_PER_MS - 1));
    assign half_tick = ms_tick && (half_cnt_q == HALF_W'(BLINK_HALF_MS - 1));

    always_ff @(posedge clk20_g) begin
        if (reset_i) begin
            us_cnt_q   <= '0;
            ms_cnt_q   <= '0;
            half_cnt_q <= '0;
            blink_q    <= 1'b0;
        end else begin
            us_cnt_q <= us_tick ? '0 : us_cnt_q + 1'b1;
            if (us_tick) begin
                ms_cnt_q <= ms_tick ? '0 : ms_cnt_q + 1'b1;
            end
            if (ms_tick) begin
                half_cnt_q <= half_tick ? '0 : half_cnt_q + 1'b1;
            end
            if (half_tick) begin
                blink_q <= ~blink_q;
            end
        end
    end

    // dark unless an error is latched and not masked
    assign led_o = blink_q && test_err_i && !led_mask_i;

endmodule

// File: eth_test_top.sv
`timescale 1ns/100ps
/*
 * ethernet test harness top level
 * register block, frame generator and checker, link monitor, status LED
 */
module eth_test_top
    import eth_test_pkg::*;
    import regs_pkg::*;
#(
    parameter int PORT_COUNT    = 4,
    parameter int FRAME_LEN     = 64,
    parameter int CLK_PER_US    = 20,
    parameter int BLINK_HALF_MS = 125
) (
    input  logic                          clk20_g,
    input  logic                          reset_i,
    // register bus
    input  logic                          wr_en_i,
    input  logic                          rd_en_i,
    input  reg_addr_t                     addr_i,
    input  reg_data_t                     wdata_i,
    output reg_data_t                     rdata_o,
    output logic                          rd_valid_o,
    // test streams, looped outside
    output byte_stream_t                  tx_stream_o,
    input  byte_stream_t                  rx_stream_i,
    // PHY side status and receive strobes
    input  port_status_t [PORT_COUNT-1:0] port_status_i,
    input  logic [PORT_COUNT-1:0]         rx_bad_i,
    input  logic [PORT_COUNT-1:0]         rx_err_i,
    output logic                          led_o
);

    ctrl_reg_t                   ctrl;
    logic                        err_clear;
    logic                        test_err;
    err_count_t                  good_frames;
    logic [PORT_COUNT-1:0]       link_up;
    err_count_t [PORT_COUNT-1:0] rx_err_count;

    // ------------------------------------------------------------------------
    // registers
    // ------------------------------------------------------------------------
    ctrl_regs #(
        .PORT_COUNT (PORT_COUNT)
    ) ctrl_regs_i (
        .clk20_g        (clk20_g),
        .reset_i        (reset_i),
        .wr_en_i        (wr_en_i),
        .rd_en_i        (rd_en_i),
        .addr_i         (addr_i),
        .wdata_i        (wdata_i),
        .rdata_o        (rdata_o),
        .rd_valid_o     (rd_valid_o),
        .test_err_i     (test_err),
        .good_frames_i  (good_frames),
        .link_up_i      (link_up),
        .rx_err_count_i (rx_err_count),
        .ctrl_o         (ctrl),
        .err_clear_o    (err_clear)
    );

    // ------------------------------------------------------------------------
    // frame test path
    // ------------------------------------------------------------------------
    test_frame_gen #(
        .FRAME_LEN (FRAME_LEN)
    ) test_frame_gen_i (
        .clk20_g     (clk20_g),
        .reset_i     (reset_i),
        .run_i       (ctrl.run),
        .tx_stream_o (tx_stream_o)
    );

    test_frame_chk #(
        .FRAME_LEN (FRAME_LEN)
    ) test_frame_chk_i (
        .clk20_g       (clk20_g),
        .reset_i       (reset_i),
        .rx_stream_i   (rx_stream_i),
        .err_clear_i   (err_clear),
        .test_err_o    (test_err),
        .good_frames_o (good_frames)
    );

    // link state and per port error counts
    link_monitor #(
        .PORT_COUNT (PORT_COUNT)
    ) link_monitor_i (
        .clk20_g        (clk20_g),
        .reset_i        (reset_i),
        .port_status_i  (port_status_i),
        .rx_bad_i       (rx_bad_i),
        .rx_err_i       (rx_err_i),
        .link_up_o      (link_up),
        .rx_err_count_o (rx_err_count)
    );

    led_blinker #(
        .CLK_PER_US    (CLK_PER_US),
        .BLINK_HALF_MS (BLINK_HALF_MS)
    ) led_blinker_i (
        .clk20_g    (clk20_g),
        .reset_i    (reset_i),
        .test_err_i (test_err),
        .led_mask_i (ctrl.led_mask),
        .led_o      (led_o)
    );

endmodule

// File: tb_eth_test.sv
`timescale 1ns/100ps
/*
 * directed testbench for the ethernet test harness
 * loops the generator back into the checker, drives registers and PHY status
 */
module tb_eth_test
    import eth_test_pkg::*;
    import regs_pkg::*;
();

    localparam int PORT_COUNT    = 4;
    localparam int FRAME_LEN     = 8;
    localparam int CLK_PER_US    = 2;
    localparam int BLINK_HALF_MS = 1;
    localparam int GAP_IDLE      = 12;
    localparam int WAIT_LIMIT    = 200;
    // longer than one gap, a restarting generator would show up
    localparam int QUIET_CYCLES  = GAP_IDLE + 4;
    // a full blink period in clocks plus margin
    localparam int LED_LIMIT     = 2 * BLINK_HALF_MS * 1000 * CLK_PER_US + 100;

    logic                          clk20_g;
    logic                          reset_i;
    logic                          wr_en;
    logic                          rd_en;
    reg_addr_t                     addr;
    reg_data_t                     wdata;
    reg_data_t                     rdata;
    logic                          rd_valid;
    byte_stream_t                  tx_stream;
    byte_stream_t                  rx_stream;
    port_status_t [PORT_COUNT-1:0] port_status;
    logic [PORT_COUNT-1:0]         rx_bad;
    logic [PORT_COUNT-1:0]         rx_err;
    logic                          led;

    integer seed = 32'hc01d;
    // frame number the generator sends next, good frames the checker should hold
    int     gen_frame;
    int     exp_good;
    logic   corrupt_pend;

    initial clk20_g = 1'b0;
    always #4 clk20_g = ~clk20_g;

    eth_test_top #(
        .PORT_COUNT    (PORT_COUNT),
        .FRAME_LEN     (FRAME_LEN),
        .CLK_PER_US    (CLK_PER_US),
        .BLINK_HALF_MS (BLINK_HALF_MS)
    ) dut_i (
        .clk20_g       (clk20_g),
        .reset_i       (reset_i),
        .wr_en_i       (wr_en),
        .rd_en_i       (rd_en),
        .addr_i        (addr),
        .wdata_i       (wdata),
        .rdata_o       (rdata),
        .rd_valid_o    (rd_valid),
        .tx_stream_o   (tx_stream),
        .rx_stream_i   (rx_stream),
        .port_status_i (port_status),
        .rx_bad_i      (rx_bad),
        .rx_err_i      (rx_err),
        .led_o         (led)
    );

    // ------------------------------------------------------------------------
    // loopback, tx back into rx, one byte flipped on request
    // ------------------------------------------------------------------------
    always @(posedge clk20_g) begin
        #1;
        rx_stream = tx_stream;
        if (corrupt_pend && tx_stream.valid && !tx_stream.sof) begin
            rx_stream.data = tx_stream.data ^ 8'h40;
            corrupt_pend   = 1'b0;
        end
    end

    // ------------------------------------------------------------------------
    // compare and wait helpers
    // ------------------------------------------------------------------------
    task automatic abort_run();
        $display("Test failures found");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic timed_out(input string what);
        $display("timeout while waiting for %s", what);
        abort_run();
    endtask

    task automatic check_data(input string name, input reg_data_t got, input reg_data_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_stream(input string name, input byte_stream_t got,
                                input byte_stream_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    // inputs change and outputs are sampled just after the edge
    task automatic next_cycle();
        @(posedge clk20_g);
        #1;
    endtask

    // byte k of frame f is f + k
    function automatic byte_stream_t pattern_beat(input int f, input int k);
        byte_stream_t b;
        b.valid = 1'b1;
        b.sof   = (k == 0);
        b.eof   = (k == FRAME_LEN - 1);
        b.data  = 8'(f + k);
        return b;
    endfunction

    task automatic write_reg(input reg_addr_t a, input reg_data_t d);
        wr_en = 1'b1;
        addr  = a;
        wdata = d;
        next_cycle();
        wr_en = 1'b0;
    endtask

    task automatic read_reg(input reg_addr_t a, output reg_data_t d);
        check_bit("rd_valid_o", rd_valid, 1'b0);
        rd_en = 1'b1;
        addr  = a;
        next_cycle();
        rd_en = 1'b0;
        // valid exactly one cycle after the strobe
        check_bit("rd_valid_o", rd_valid, 1'b1);
        d = rdata;
        next_cycle();
        check_bit("rd_valid_o", rd_valid, 1'b0);
    endtask

    task automatic expect_reg(input string name, input reg_addr_t a, input reg_data_t exp);
        reg_data_t d;
        read_reg(a, d);
        check_data(name, d, exp);
    endtask

    task automatic expect_frame(input int f);
        for (int k = 0; k < FRAME_LEN; k++) begin
            check_stream("tx_stream_o", tx_stream, pattern_beat(f, k));
            next_cycle();
        end
    endtask

    task automatic wait_frame_start(output int idle);
        idle = 0;
        while (!tx_stream.valid) begin
            if (idle >= WAIT_LIMIT) begin
                timed_out("the next frame");
            end
            idle++;
            next_cycle();
        end
    endtask

    // returns on the cycle after eof
    task automatic wait_frame_end();
        int n = 0;
        while (!(tx_stream.valid && tx_stream.eof)) begin
            if (n >= WAIT_LIMIT) begin
                timed_out("the end of a frame");
            end
            n++;
            next_cycle();
        end
        next_cycle();
    endtask

    // clear run, then count the frames still leaving until tx goes quiet
    task automatic stop_run(input logic mask, input int exp_frames);
        int frames = 0;
        int quiet  = 0;
        int n      = 0;
        write_reg(ADDR_CTRL, {30'd0, mask, 1'b0});
        while (quiet < QUIET_CYCLES) begin
            if (n >= WAIT_LIMIT) begin
                timed_out("the generator to go idle");
            end
            if (tx_stream.valid) begin
                quiet = 0;
                if (tx_stream.eof) begin
                    frames++;
                end
            end else begin
                quiet++;
            end
            n++;
            next_cycle();
        end
        check_data("frames after run cleared", reg_data_t'(frames), reg_data_t'(exp_frames));
    endtask

    task automatic hold_led_low(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            check_bit("led_o", led, 1'b0);
            next_cycle();
        end
    endtask

    task automatic wait_led(input logic level);
        int n = 0;
        while (led !== level) begin
            if (n >= LED_LIMIT) begin
                timed_out("the LED to change level");
            end
            n++;
            next_cycle();
        end
    endtask

    // ------------------------------------------------------------------------
    // directed tests
    // ------------------------------------------------------------------------
    task automatic reset_and_regs();
        for (int a = 0; a < 16; a++) begin
            expect_reg($sformatf("reg 0x%h after reset", a), reg_addr_t'(a), '0);
        end
        write_reg(ADDR_CTRL, 32'd3);
        expect_reg("CTRL", ADDR_CTRL, 32'd3);
        // run was on for less than a frame, so exactly one frame went out
        stop_run(1'b0, 1);
        gen_frame = gen_frame + 1;
        exp_good  = exp_good + 1;
    endtask

    task automatic gen_pattern();
        int idle;
        write_reg(ADDR_CTRL, 32'd1);
        check_bit("tx_stream_o.valid", tx_stream.valid, 1'b0);
        // sof on the cycle after run is seen
        next_cycle();
        for (int i = 0; i < 3; i++) begin
            if (i > 0) begin
                wait_frame_start(idle);
                check_data("idle cycles between frames", reg_data_t'(idle),
                           reg_data_t'(GAP_IDLE));
            end
            expect_frame(gen_frame);
            gen_frame = gen_frame + 1;
        end
        stop_run(1'b0, 0);
        exp_good = exp_good + 3;
    endtask

    task automatic clean_loopback();
        write_reg(ADDR_CTRL, 32'd1);
        for (int i = 0; i < 4; i++) begin
            wait_frame_end();
        end
        stop_run(1'b0, 0);
        exp_good = exp_good + 4;
        expect_reg("GOOD_FRAMES", ADDR_GOOD_FRAMES, reg_data_t'(exp_good));
        expect_reg("STATUS", ADDR_STATUS, 32'd0);
    endtask

    task automatic error_latch();
        corrupt_pend = 1'b1;
        write_reg(ADDR_CTRL, 32'd1);
        // first frame bad, two clean ones behind it
        for (int i = 0; i < 3; i++) begin
            wait_frame_end();
        end
        stop_run(1'b0, 0);
        exp_good = exp_good + 2;
        expect_reg("STATUS", ADDR_STATUS, 32'd1);
        expect_reg("GOOD_FRAMES", ADDR_GOOD_FRAMES, reg_data_t'(exp_good));
        write_reg(ADDR_CTRL, 32'd4);
        // clear pulse reaches the checker one edge later
        next_cycle();
        expect_reg("STATUS", ADDR_STATUS, 32'd0);
    endtask

    task automatic link_counters();
        int strobes;
        int r;
        port_status[1] = '{duplex: 1'b1, speed: SPEED_1G, link: 1'b1};
        // 100M, link up but must not count
        port_status[2] = '{duplex: 1'b1, speed: 2'd1, link: 1'b1};
        next_cycle();
        r       = $random(seed);
        strobes = 4 + (r & 15);
        for (int i = 0; i < strobes; i++) begin
            r = $random(seed);
            // bad, err or both, one count per cycle
            rx_bad[1] = r[0];
            rx_err[1] = !r[0] || r[1];
            rx_bad[2] = r[0];
            rx_err[2] = !r[0];
            // port 0 has no link at all
            rx_bad[0] = r[3];
            next_cycle();
            rx_bad = '0;
            rx_err = '0;
            if (r[2]) begin
                next_cycle();
            end
        end
        expect_reg("port 1 count", reg_addr_t'(ADDR_RX_ERR_BASE + 1), reg_data_t'(strobes));
        expect_reg("port 2 count", reg_addr_t'(ADDR_RX_ERR_BASE + 2), 32'd0);
        expect_reg("port 0 count", ADDR_RX_ERR_BASE, 32'd0);
        expect_reg("STATUS", ADDR_STATUS, 32'h0000_0200);
        // link drop, counter held at zero
        port_status[1].link = 1'b0;
        next_cycle();
        next_cycle();
        expect_reg("port 1 count", reg_addr_t'(ADDR_RX_ERR_BASE + 1), 32'd0);
        expect_reg("STATUS", ADDR_STATUS, 32'd0);
        port_status = '0;
    endtask

    task automatic led_blink();
        hold_led_low(LED_LIMIT);
        corrupt_pend = 1'b1;
        write_reg(ADDR_CTRL, 32'd1);
        wait_frame_end();
        stop_run(1'b0, 0);
        expect_reg("STATUS", ADDR_STATUS, 32'd1);
        wait_led(1'b1);
        wait_led(1'b0);
        // mask on, error still latched
        write_reg(ADDR_CTRL, 32'd2);
        hold_led_low(LED_LIMIT);
    endtask

    initial begin
        reset_i      = 1'b1;
        wr_en        = 1'b0;
        rd_en        = 1'b0;
        addr         = '0;
        wdata        = '0;
        rx_stream    = '0;
        port_status  = '0;
        rx_bad       = '0;
        rx_err       = '0;
        corrupt_pend = 1'b0;
        gen_frame    = 0;
        exp_good     = 0;
        repeat (2) @(posedge clk20_g);
        #1;
        reset_i = 1'b0;
        reset_and_regs();
        gen_pattern();
        clean_loopback();
        error_latch();
        link_counters();
        led_blink();
        $display("All tests passed!");
        $finish;
    end

endmodule

// File: compile.f
eth_test_pkg.sv
regs_pkg.sv
ctrl_regs.sv
test_frame_gen.sv
test_frame_chk.sv
link_monitor.sv
led_blinker.sv
eth_test_top.sv
tb_eth_test.sv

// File: Makefile
# Verilator build, run and lint for the ethernet test harness

VERILATOR  ?= verilator
TOP        ?= tb_eth_test
RTL_TOP    ?= eth_test_top
FILELIST   ?= compile.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing -Wno-fatal -j 0
LINT_FLAGS ?= --lint-only -Wall
RTL_FILES  ?= eth_test_pkg.sv regs_pkg.sv ctrl_regs.sv test_frame_gen.sv \
              test_frame_chk.sv link_monitor.sv led_blinker.sv eth_test_top.sv
PASS_TEXT  ?= All tests passed!

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_FILES)

clean:
	rm -rf $(OBJ_DIR)
